/* sim/cpu_trace.txt */
# I lines hold four program words each, placed in order from address 0
# D lines give an address and an initial data word, S lines an expected store in order
# The P line gives the expected halt PC
I 05A00093 FFD00113 00400393 10000513
I 002081B3 00352023 402081B3 00352223
I 0020F1B3 00352423 0020E1B3 00352623
I 0020C1B3 00352823 001121B3 00352A23
I 001131B3 00352C23 007091B3 00352E23
I 007151B3 02352023 407151B3 02352223
I 00F0F193 02352423 7000E193 02352623
I 0FF14193 02352823 00012193 02352A23
I 08052583 08452603 04B52023 04C52223
I 04052423 00108463 06052023 00208463
I 06152023 00209463 06052223 00109463
I 06252223 00114463 06052423 0020C463
I 06152423 0020D463 06052623 00115463
I 06252623 008006EF 06052823 06D52823
I 00000717 00C707E7 06052A23 06E52A23
I 06F52C23 12345837 07052E23 0000006F
D 00000180 CAFEF00D
D 00000184 12345678
S 00000100 00000057
S 00000104 0000005D
S 00000108 00000058
S 0000010C FFFFFFFF
S 00000110 FFFFFFA7
S 00000114 00000001
S 00000118 00000000
S 0000011C 000005A0
S 00000120 0FFFFFFF
S 00000124 FFFFFFFF
S 00000128 0000000A
S 0000012C 0000075A
S 00000130 FFFFFF02
S 00000134 00000001
S 00000140 CAFEF00D
S 00000144 12345678
S 00000148 00000000
S 00000160 0000005A
S 00000164 FFFFFFFD
S 00000168 0000005A
S 0000016C FFFFFFFD
S 00000170 000000D8
S 00000174 000000E0
S 00000178 000000E8
S 0000017C 12345000
P 000000FC

/* verilog.f */
+incdir+source
source/riscv_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/control.sv
source/signext.sv
source/alu.sv
source/regfile.sv
source/cpu.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: rv32i_single_cycle

sources:
  - include_dirs:
      - source
    files:
      - source/riscv_isa_pkg.sv
      - source/cpu_ctrl_pkg.sv
      - source/control.sv
      - source/signext.sv
      - source/alu.sv
      - source/regfile.sv
      - source/cpu.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/cpu_chk.sv
      - sim/cpu_tb.sv

/* sim/cpu_tb.sv */
module cpu_tb;

    import riscv_isa_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 4;
    localparam int          MEM_WORDS    = 256;
    localparam int          IDX_HI       = $clog2(MEM_WORDS) + 1;
    localparam int unsigned RANDOM_SEED  = 32'hae338ebf;
    localparam string       TRACE_FILE   = "sim/cpu_trace.txt";

    // sw x0, 0(x0) held on the fetch port while in reset
    localparam word_t       RESET_FETCH  = 32'h0000_2023;

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    word_t exp_store_addr [$];
    word_t exp_store_data [$];
    word_t exp_halt_pc;
    word_t last_pc;
    int    prog_words;
    int    store_count;
    int    cycle_count;
    int    cycle_limit;
    logic  halted;

    cpu dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign imem_data  = !rst_n ? RESET_FETCH
                      : (imem_addr < word_t'(MEM_WORDS * 4)) ? imem[imem_addr[IDX_HI:2]]
                      : ~imem_addr;
    assign dmem_rdata = (dmem_addr < word_t'(MEM_WORDS * 4)) ? dmem[dmem_addr[IDX_HI:2]]
                                                               : ~dmem_addr;

    always @(posedge clk) begin
        if (dmem_we && dmem_addr < word_t'(MEM_WORDS * 4)) begin
            dmem[dmem_addr[IDX_HI:2]] <= dmem_wdata;
        end
    end

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_store(string name, word_t exp_addr, word_t exp_data,
                               word_t act_addr, word_t act_data);
        if (exp_addr !== act_addr || exp_data !== act_data) begin
            $display("error %s expected addr %h data %h, actual addr %h data %h",
                     name, exp_addr, exp_data, act_addr, act_data);
            end_in_failure();
        end
    endtask

    task automatic check_pc(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("error %s expected %h, actual %h", name, expected, actual);
            end_in_failure();
        end
    endtask

    // Stores are compared in program order
    task automatic compare_store(word_t addr, word_t data);
        string name;
        name = $sformatf("store %0d", store_count);
        if (store_count >= exp_store_addr.size()) begin
            $display("unexpected extra store of %h to address %h", data, addr);
            end_in_failure();
        end else begin
            check_store(name, exp_store_addr[store_count], exp_store_data[store_count],
                        addr, data);
            store_count++;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        byte   kind;
        string line;
        word_t v [4];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", TRACE_FILE);
            end_in_failure();
        end else begin
            while ($fgets(line, fd) > 0) begin
                kind = line[0];
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                            v[0], v[1], v[2], v[3]);
                case (kind)
                    "I": begin
                        for (int k = 0; k < n; k++) begin
                            imem[prog_words] = v[k];
                            prog_words++;
                        end
                    end
                    "D": dmem[v[0][IDX_HI:2]] = v[1];
                    "S": begin
                        exp_store_addr.push_back(v[0]);
                        exp_store_data.push_back(v[1]);
                    end
                    "P": exp_halt_pc = v[0];
                    default: ;
                endcase
            end
            $fclose(fd);
        end
    endtask

    // Outputs at the commit edge still belong to the retiring instruction
    always @(posedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("an assertion on the core ports failed");
            end_in_failure();
        end else if (!rst_n) begin
            last_pc = 32'hffff_ffff;
            if (dmem_we !== 1'b0) begin
                $display("a store was issued while reset was active");
                end_in_failure();
            end
        end else if (!halted) begin
            cycle_count++;
            if (dmem_we) begin
                compare_store(dmem_addr, dmem_wdata);
            end
            halted  = (imem_addr == last_pc);
            last_pc = imem_addr;
        end
    end

    initial begin
        rst_n       = 1'b0;
        halted      = 1'b0;
        prog_words  = 0;
        store_count = 0;
        cycle_count = 0;
        exp_halt_pc = '0;
        void'($urandom(RANDOM_SEED));
        // Random background makes stray loads visible
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = ~word_t'(i * 4);
            dmem[i] = $urandom();
        end
        load_trace();
        cycle_limit = 64 * (prog_words + exp_store_addr.size());

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        while (!halted && cycle_count < cycle_limit) begin
            @(negedge clk);
        end

        if (!halted) begin
            $display("the program never reached its halt loop within %0d cycles", cycle_limit);
            end_in_failure();
        end else if (store_count != exp_store_addr.size()) begin
            $display("missing stores, only %0d of %0d were seen",
                     store_count, exp_store_addr.size());
            end_in_failure();
        end else begin
            check_pc("halt pc", exp_halt_pc, last_pc);
            if (dut0.chk0.fail_count == 0) begin
                $display("Test completed successfully");
                $finish;
            end else begin
                $display("an assertion on the core ports failed");
                end_in_failure();
            end
        end
    end

endmodule

/* sim/cpu_chk.sv */
`include "cpu_consts.svh"

module cpu_chk (
    input logic                 clk,
    input logic                 rst_n,
    input riscv_isa_pkg::word_t imem_addr,
    input riscv_isa_pkg::word_t dmem_addr,
    input logic                 dmem_we
);

    int fail_count = 0;

    fetch_aligned: assert property (@(posedge clk) rst_n |-> imem_addr[1:0] == 2'b00)
        else begin
            $error("fetch address %h is not word aligned", imem_addr);
            fail_count++;
        end

    // Any reset cycle leaves the PC at its reset value
    pc_after_reset: assert property (@(posedge clk) !rst_n |=> imem_addr == `RESET_PC)
        else begin
            $error("fetch address %h after reset is not the reset PC", imem_addr);
            fail_count++;
        end

    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
        else begin
            $error("store enable high during reset");
            fail_count++;
        end

    store_enable_known: assert property (@(posedge clk) !$isunknown(dmem_we))
        else begin
            $error("store enable is unknown");
            fail_count++;
        end

    store_aligned: assert property (@(posedge clk) dmem_we |-> dmem_addr[1:0] == 2'b00)
        else begin
            $error("store address %h is not word aligned", dmem_addr);
            fail_count++;
        end

endmodule

bind cpu cpu_chk chk0 (.*);

/* source/cpu.sv */
`include "cpu_consts.svh"

module cpu (
    input  logic                   clk,
    input  logic                   rst_n,
    output riscv_isa_pkg::word_t   imem_addr,
    input  riscv_isa_pkg::word_t   imem_data,
    output riscv_isa_pkg::word_t   dmem_addr,
    output riscv_isa_pkg::word_t   dmem_wdata,
    output logic                   dmem_we,
    input  riscv_isa_pkg::word_t   dmem_rdata
);

    import riscv_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    instr_u   instr;
    word_t    pc;
    word_t    pc_next;
    word_t    pc_plus_four;
    word_t    second_add;
    word_t    immediate;
    word_t    read_data1;
    word_t    read_data2;
    word_t    alu_src2;
    word_t    alu_result;
    word_t    write_back;
    logic     alu_zero;
    logic     alu_last_bit;

    alu_op_e  alu_op;
    imm_src_e imm_src;
    wb_src_e  wb_src;
    add_src_e add_src;
    logic     mem_write;
    logic     reg_write;
    logic     alu_src;
    logic     pc_src;

    assign instr     = imem_data;
    assign imem_addr = pc;

    // Program counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus_four = pc + word_t'(4);

    // Second adder serves branches, jumps, lui and auipc
    always_comb begin
        case (add_src)
            ADD_IMM:     second_add = immediate;
            ADD_RS1_IMM: second_add = read_data1 + immediate;
            default:     second_add = pc + immediate;
        endcase
    end

    // jalr target has bit 0 cleared
    assign pc_next = pc_src ? {second_add[`XLEN-1:1], 1'b0} : pc_plus_four;

    control control0 (
        .instr        (instr),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .alu_op       (alu_op),
        .imm_src      (imm_src),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .alu_src      (alu_src),
        .wb_src       (wb_src),
        .pc_src       (pc_src),
        .add_src      (add_src)
    );

    signext signext0 (
        .instr     (instr),
        .imm_src   (imm_src),
        .immediate (immediate)
    );

    regfile regfile0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr1        (instr.r.rs1),
        .addr2        (instr.r.rs2),
        .addr3        (instr.r.rd),
        .write_enable (reg_write),
        .write_data   (write_back),
        .read_data1   (read_data1),
        .read_data2   (read_data2)
    );

    assign alu_src2 = alu_src ? immediate : read_data2;

    alu alu0 (
        .alu_op   (alu_op),
        .src1     (read_data1),
        .src2     (alu_src2),
        .result   (alu_result),
        .zero     (alu_zero),
        .last_bit (alu_last_bit)
    );

    always_comb begin
        case (wb_src)
            WB_MEM:  write_back = dmem_rdata;
            WB_PC4:  write_back = pc_plus_four;
            WB_ADD:  write_back = second_add;
            default: write_back = alu_result;
        endcase
    end

    // Data memory port, no store while in reset
    assign dmem_addr  = alu_result;
    assign dmem_wdata = read_data2;
    assign dmem_we    = mem_write & rst_n;

endmodule

/* source/regfile.sv */
`include "cpu_consts.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`REG_ADDR_W-1:0]    addr1,
    input  logic [`REG_ADDR_W-1:0]    addr2,
    input  logic [`REG_ADDR_W-1:0]    addr3,
    input  logic                      write_enable,
    input  riscv_isa_pkg::word_t      write_data,
    output riscv_isa_pkg::word_t      read_data1,
    output riscv_isa_pkg::word_t      read_data2
);

    import riscv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && addr3 != '0) begin
            regs[addr3] <= write_data;
        end
    end

    // Asynchronous reads
    assign read_data1 = (addr1 == '0) ? '0 : regs[addr1];
    assign read_data2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

/* source/alu.sv */
`include "cpu_consts.svh"

module alu (
    input  cpu_ctrl_pkg::alu_op_e  alu_op,
    input  riscv_isa_pkg::word_t   src1,
    input  riscv_isa_pkg::word_t   src2,
    output riscv_isa_pkg::word_t   result,
    output logic                   zero,
    output logic                   last_bit
);

    import cpu_ctrl_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = src2[SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, src1 < src2};
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

    // Set by slt/sltu, read by blt and bge
    assign last_bit = result[0];

endmodule

/* source/signext.sv */
`include "cpu_consts.svh"

module signext (
    input  riscv_isa_pkg::instr_u    instr,
    input  cpu_ctrl_pkg::imm_src_e   imm_src,
    output riscv_isa_pkg::word_t     immediate
);

    import cpu_ctrl_pkg::*;

    always_comb begin
        case (imm_src)
            IMM_I: immediate = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            IMM_S: immediate = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            IMM_B: begin
                immediate = {{(`XLEN-12){instr.b.imm_12}}, instr.b.imm_11,
                             instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            // Upper 20 bits, low 12 cleared
            IMM_U: immediate = {instr.u.imm, 12'b0};
            IMM_J: begin
                immediate = {{(`XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12,
                             instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: immediate = '0;
        endcase
    end

endmodule

/* source/control.sv */
module control (
    input  riscv_isa_pkg::instr_u    instr,
    input  logic                     alu_zero,
    input  logic                     alu_last_bit,
    output cpu_ctrl_pkg::alu_op_e    alu_op,
    output cpu_ctrl_pkg::imm_src_e   imm_src,
    output logic                     mem_write,
    output logic                     reg_write,
    output logic                     alu_src,
    output cpu_ctrl_pkg::wb_src_e    wb_src,
    output logic                     pc_src,
    output cpu_ctrl_pkg::add_src_e   add_src
);

    import riscv_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    alu_op_e arith_op;
    logic    alt_funct7;

    assign alt_funct7 = (instr.r.funct7 == F7_ALT);

    // ALU decoder for register and immediate arithmetic
    always_comb begin
        case (instr.r.funct3)
            F3_ADD_SUB: arith_op = (instr.r.opcode == OP_R && alt_funct7) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = alt_funct7 ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    // Main decoder
    always_comb begin
        alu_op    = ALU_ADD;
        imm_src   = IMM_I;
        mem_write = 1'b0;
        reg_write = 1'b0;
        alu_src   = 1'b0;
        wb_src    = WB_ALU;
        pc_src    = 1'b0;
        add_src   = ADD_PC_IMM;

        case (instr.r.opcode)
            OP_R: begin
                alu_op    = arith_op;
                reg_write = 1'b1;
            end
            OP_I: begin
                alu_op    = arith_op;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LOAD: begin
                // Word access only
                alu_src   = 1'b1;
                wb_src    = WB_MEM;
                reg_write = (instr.i.funct3 == F3_LW);
            end
            OP_STORE: begin
                imm_src   = IMM_S;
                alu_src   = 1'b1;
                mem_write = (instr.s.funct3 == F3_SW);
            end
            OP_BRANCH: begin
                imm_src = IMM_B;
                case (instr.b.funct3)
                    F3_BEQ: begin
                        alu_op = ALU_SUB;
                        pc_src = alu_zero;
                    end
                    F3_BNE: begin
                        alu_op = ALU_SUB;
                        pc_src = !alu_zero;
                    end
                    F3_BLT: begin
                        alu_op = ALU_SLT;
                        pc_src = alu_last_bit;
                    end
                    F3_BGE: begin
                        alu_op = ALU_SLT;
                        pc_src = !alu_last_bit;
                    end
                    default: pc_src = 1'b0;
                endcase
            end
            OP_JAL: begin
                imm_src   = IMM_J;
                wb_src    = WB_PC4;
                reg_write = 1'b1;
                pc_src    = 1'b1;
            end
            OP_JALR: begin
                add_src   = ADD_RS1_IMM;
                wb_src    = WB_PC4;
                reg_write = 1'b1;
                pc_src    = 1'b1;
            end
            OP_LUI: begin
                imm_src   = IMM_U;
                add_src   = ADD_IMM;
                wb_src    = WB_ADD;
                reg_write = 1'b1;
            end
            OP_AUIPC: begin
                imm_src   = IMM_U;
                wb_src    = WB_ADD;
                reg_write = 1'b1;
            end
            default: reg_write = 1'b0;
        endcase
    end

endmodule

/* source/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SLTU = 4'b0110,
        ALU_SLL  = 4'b0111,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } imm_src_e;

    // Value written back to rd
    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10,
        WB_ADD = 2'b11
    } wb_src_e;

    // Operands of the second adder
    typedef enum logic [1:0] {
        ADD_PC_IMM  = 2'b00,
        ADD_IMM     = 2'b01,
        ADD_RS1_IMM = 2'b10
    } add_src_e;

endpackage

/* source/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    `include "cpu_consts.svh"

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`OPCODE_W-1:0] opcode_t;
    typedef logic [`FUNCT3_W-1:0] funct3_t;
    typedef logic [`FUNCT7_W-1:0] funct7_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Base instruction formats, msb first
    typedef struct packed {
        funct7_t   funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        funct3_t   funct3;
        reg_addr_t rd;
        opcode_t   opcode;
    } r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        funct3_t     funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        funct3_t    funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        funct3_t    funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } j_t;

    // One fetched word, read through whichever format applies
    typedef union packed {
        r_t r;
        i_t i;
        s_t s;
        b_t b;
        u_t u;
        j_t j;
    } instr_u;

    // Major opcodes
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // Arithmetic funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch and memory funct3
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_SW  = 3'b010;

    // Selects sub and sra
    localparam funct7_t F7_ALT = 7'b0100000;

endpackage

/* source/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width of the core
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// First instruction fetched after reset
`define RESET_PC 32'h0000_0000

// Instruction fields that do not scale with XLEN
`define OPCODE_W 7
`define FUNCT3_W 3
`define FUNCT7_W 7

`endif
